// ==== alu.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module alu import rv_core_pkg::*; (
  input  logic [`XLEN-1:0] a_i,
  input  logic [`XLEN-1:0] b_i,
  input  alu_op_e          op_i,
  output logic [`XLEN-1:0] result_o,
  output logic             equal_o
);

  logic [4:0] shamt;
  logic       less;

  assign shamt = b_i[4:0];
  assign less  = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = {{(`XLEN-1){1'b0}}, less};
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      // lui passes the upper immediate through
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // branch condition for beq / bne
  assign equal_o = (a_i == b_i);

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module hazard_unit import rv_core_pkg::*; (
  input  logic [`REG_ADDR_W-1:0] id_rs1_i,
  input  logic [`REG_ADDR_W-1:0] id_rs2_i,
  input  logic [`REG_ADDR_W-1:0] ex_rs1_i,
  input  logic [`REG_ADDR_W-1:0] ex_rs2_i,
  input  logic [`REG_ADDR_W-1:0] ex_rd_i,
  input  logic                   ex_mem_read_i,
  input  logic [`REG_ADDR_W-1:0] mem_rd_i,
  input  logic                   mem_reg_write_i,
  input  logic [`REG_ADDR_W-1:0] wb_rd_i,
  input  logic                   wb_reg_write_i,
  input  logic                   ex_redirect_i,
  output fwd_sel_e               forward_a_o,
  output fwd_sel_e               forward_b_o,
  output logic                   stall_if_id_o,
  output logic                   flush_id_o,
  output logic                   flush_ex_o
);

  logic load_use;

  // the younger result in MEM wins over WB
  function automatic fwd_sel_e fwd_pick(input logic [`REG_ADDR_W-1:0] src);
    fwd_sel_e sel;
    if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == src) begin
      sel = FWD_MEM;
    end else if (wb_reg_write_i && wb_rd_i != '0 && wb_rd_i == src) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  always_comb begin
    forward_a_o = fwd_pick(ex_rs1_i);
    forward_b_o = fwd_pick(ex_rs2_i);
  end

  // load data is not ready until WB, so hold the consumer one cycle
  assign load_use = ex_mem_read_i && ex_rd_i != '0 &&
                    (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

  assign stall_if_id_o = load_use;
  assign flush_id_o    = ex_redirect_i;
  assign flush_ex_o    = load_use | ex_redirect_i;

endmodule

// ==== insn_decoder.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module insn_decoder import rv_core_pkg::*; (
  input  logic [`XLEN-1:0]       insn_i,
  output ctrl_t                  ctrl_o,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  output logic [`REG_ADDR_W-1:0] rd_addr_o,
  output logic [`XLEN-1:0]       imm_o
);

  //////////////////////////////
  // field extraction
  //////////////////////////////
  opcode_e          opcode;
  logic [2:0]       funct3;
  logic             funct7b5;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;
  alu_op_e          alu_sel;
  logic             use_rs1;
  logic             use_rs2;
  logic             use_rd;

  assign opcode   = opcode_e'(insn_i[6:0]);
  assign funct3   = insn_i[14:12];
  assign funct7b5 = insn_i[30];

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};

  //////////////////////////////
  // alu control
  //////////////////////////////
  // funct7 bit 30 selects sub only for register ops, sra for both
  always_comb begin
    case (funct3)
      3'b000:  alu_sel = (opcode == OP_REG && funct7b5) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = funct7b5 ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      3'b111:  alu_sel = ALU_AND;
      default: alu_sel = ALU_ADD;
    endcase
  end

  //////////////////////////////
  // main decode
  //////////////////////////////
  always_comb begin
    ctrl_o  = '0;
    imm_o   = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    case (opcode)
      OP_REG: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = alu_sel;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
        use_rd           = 1'b1;
      end
      OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_b_imm = 1'b1;
        ctrl_o.alu_op    = alu_sel;
        imm_o            = imm_i;
        use_rs1          = 1'b1;
        use_rd           = 1'b1;
      end
      OP_LUI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_b_imm = 1'b1;
        ctrl_o.alu_op    = ALU_PASS_B;
        imm_o            = imm_u;
        use_rd           = 1'b1;
      end
      OP_LOAD: begin
        // word loads only
        if (funct3 == 3'b010) begin
          ctrl_o.reg_write  = 1'b1;
          ctrl_o.mem_read   = 1'b1;
          ctrl_o.alu_b_imm  = 1'b1;
          ctrl_o.result_src = RES_MEM;
          imm_o             = imm_i;
          use_rs1           = 1'b1;
          use_rd            = 1'b1;
        end
      end
      OP_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl_o.mem_write = 1'b1;
          ctrl_o.alu_b_imm = 1'b1;
          imm_o            = imm_s;
          use_rs1          = 1'b1;
          use_rs2          = 1'b1;
        end
      end
      OP_BRANCH: begin
        // beq and bne
        if (funct3[2:1] == 2'b00) begin
          ctrl_o.branch    = 1'b1;
          ctrl_o.branch_ne = funct3[0];
          ctrl_o.alu_op    = ALU_SUB;
          imm_o            = imm_b;
          use_rs1          = 1'b1;
          use_rs2          = 1'b1;
        end
      end
      OP_JAL: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.jump       = 1'b1;
        ctrl_o.result_src = RES_PC4;
        imm_o             = imm_j;
        use_rd            = 1'b1;
      end
      default: begin
        ctrl_o = '0;
      end
    endcase
  end

  // unused fields read as x0 so they never look like a dependence
  assign rs1_addr_o = use_rs1 ? insn_i[19:15] : '0;
  assign rs2_addr_o = use_rs2 ? insn_i[24:20] : '0;
  assign rd_addr_o  = use_rd  ? insn_i[11:7]  : '0;

endmodule

// ==== list.f ====
+incdir+.
rv_core_pkg.sv
stage_reg.sv
insn_decoder.sv
reg_file.sv
alu.sv
hazard_unit.sv
rv_core.sv
rv_core_properties.sv
rv_core_tb.sv

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module reg_file (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [`REG_ADDR_W-1:0] rd_addr_i,
  input  logic                   rd_we_i,
  input  logic [`XLEN-1:0]       rd_wdata_i,
  output logic [`XLEN-1:0]       rs1_rdata_o,
  output logic [`XLEN-1:0]       rs2_rdata_o
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:31];

  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= rd_wdata_i;
    end
  end

  // same-cycle write is visible to the reader
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (rd_we_i && addr == rd_addr_i) begin
      val = rd_wdata_i;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rs1_rdata_o = read_port(rs1_addr_i);
    rs2_rdata_o = read_port(rs2_addr_i);
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core import rv_core_pkg::*; (
  input  logic                    CLK,
  input  logic                    RST,
  output logic [`IMEM_ADDR_W-1:0] imem_addr_o,
  input  logic [`XLEN-1:0]        imem_rdata_i,
  output dmem_req_t               dmem_o,
  input  logic [`XLEN-1:0]        dmem_rdata_i
);

  logic [`XLEN-1:0]       pc_q;
  logic [`XLEN-1:0]       pc_plus_4;
  ifid_t                  ifid_d;
  ifid_t                  ifid_q;
  idex_t                  idex_d;
  idex_t                  idex_q;
  exmem_t                 exmem_d;
  exmem_t                 exmem_q;
  memwb_t                 memwb_d;
  memwb_t                 memwb_q;
  ctrl_t                  id_ctrl;
  logic [`REG_ADDR_W-1:0] id_rs1;
  logic [`REG_ADDR_W-1:0] id_rs2;
  logic [`REG_ADDR_W-1:0] id_rd;
  logic [`XLEN-1:0]       id_imm;
  logic [`XLEN-1:0]       id_rs1_data;
  logic [`XLEN-1:0]       id_rs2_data;
  fwd_sel_e               fwd_a;
  fwd_sel_e               fwd_b;
  logic                   stall_if_id;
  logic                   flush_id;
  logic                   flush_ex;
  logic [`XLEN-1:0]       ex_src_a;
  logic [`XLEN-1:0]       ex_rs2_val;
  logic [`XLEN-1:0]       ex_src_b;
  logic [`XLEN-1:0]       ex_alu_result;
  logic                   ex_equal;
  logic                   ex_taken;
  logic [`XLEN-1:0]       ex_target;
  logic [`XLEN-1:0]       mem_fwd_val;
  logic [`XLEN-1:0]       wb_result;

  //////////////////////////////
  // fetch
  //////////////////////////////
  assign pc_plus_4   = pc_q + 32'd4;
  assign imem_addr_o = pc_q[`IMEM_ADDR_W+1:2];

  // a redirect from EX overrides the load-use hold
  always_ff @(posedge CLK) begin
    if (RST) begin
      pc_q <= `RESET_PC;
    end else if (ex_taken) begin
      pc_q <= ex_target;
    end else if (!stall_if_id) begin
      pc_q <= pc_plus_4;
    end
  end

  assign ifid_d = '{insn: imem_rdata_i, pc: pc_q};

  stage_reg #(.T(ifid_t)) u_ifid (
    .CLK(CLK), .RST(RST), .stall_i(stall_if_id), .flush_i(flush_id), .d_i(ifid_d), .q_o(ifid_q)
  );

  //////////////////////////////
  // decode
  //////////////////////////////
  insn_decoder u_dec (
    .insn_i(ifid_q.insn), .ctrl_o(id_ctrl), .rs1_addr_o(id_rs1), .rs2_addr_o(id_rs2),
    .rd_addr_o(id_rd), .imm_o(id_imm)
  );

  reg_file u_rf (
    .CLK(CLK), .RST(RST), .rs1_addr_i(id_rs1), .rs2_addr_i(id_rs2),
    .rd_addr_i(memwb_q.rd), .rd_we_i(memwb_q.reg_write), .rd_wdata_i(wb_result),
    .rs1_rdata_o(id_rs1_data), .rs2_rdata_o(id_rs2_data)
  );

  assign idex_d = '{ctrl: id_ctrl, pc: ifid_q.pc, rs1_data: id_rs1_data,
                    rs2_data: id_rs2_data, rs1: id_rs1, rs2: id_rs2, rd: id_rd, imm: id_imm};

  stage_reg #(.T(idex_t)) u_idex (
    .CLK(CLK), .RST(RST), .stall_i(1'b0), .flush_i(flush_ex), .d_i(idex_d), .q_o(idex_q)
  );

  //////////////////////////////
  // execute
  //////////////////////////////
  function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [`XLEN-1:0] reg_val,
                                               input logic [`XLEN-1:0] mem_val,
                                               input logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign ex_src_a   = fwd_mux(fwd_a, idex_q.rs1_data, mem_fwd_val, wb_result);
  assign ex_rs2_val = fwd_mux(fwd_b, idex_q.rs2_data, mem_fwd_val, wb_result);
  assign ex_src_b   = idex_q.ctrl.alu_b_imm ? idex_q.imm : ex_rs2_val;

  alu u_alu (
    .a_i(ex_src_a), .b_i(ex_src_b), .op_i(idex_q.ctrl.alu_op),
    .result_o(ex_alu_result), .equal_o(ex_equal)
  );

  // branches and jal are both pc-relative
  assign ex_target = idex_q.pc + idex_q.imm;
  assign ex_taken  = idex_q.ctrl.jump |
                     (idex_q.ctrl.branch & (ex_equal ^ idex_q.ctrl.branch_ne));

  hazard_unit u_hzd (
    .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rs1_i(idex_q.rs1), .ex_rs2_i(idex_q.rs2),
    .ex_rd_i(idex_q.rd), .ex_mem_read_i(idex_q.ctrl.mem_read),
    .mem_rd_i(exmem_q.rd), .mem_reg_write_i(exmem_q.ctrl.reg_write),
    .wb_rd_i(memwb_q.rd), .wb_reg_write_i(memwb_q.reg_write), .ex_redirect_i(ex_taken),
    .forward_a_o(fwd_a), .forward_b_o(fwd_b), .stall_if_id_o(stall_if_id),
    .flush_id_o(flush_id), .flush_ex_o(flush_ex)
  );

  assign exmem_d = '{ctrl: idex_q.ctrl, alu_result: ex_alu_result, store_data: ex_rs2_val,
                     rd: idex_q.rd, pc_plus_4: idex_q.pc + 32'd4};

  stage_reg #(.T(exmem_t)) u_exmem (
    .CLK(CLK), .RST(RST), .stall_i(1'b0), .flush_i(1'b0), .d_i(exmem_d), .q_o(exmem_q)
  );

  //////////////////////////////
  // memory
  //////////////////////////////
  assign dmem_o.en    = exmem_q.ctrl.mem_read | exmem_q.ctrl.mem_write;
  assign dmem_o.we    = exmem_q.ctrl.mem_write;
  assign dmem_o.addr  = exmem_q.alu_result[`DMEM_ADDR_W+1:2];
  assign dmem_o.wdata = exmem_q.store_data;

  // a jal in MEM forwards its link value
  assign mem_fwd_val = (exmem_q.ctrl.result_src == RES_PC4) ? exmem_q.pc_plus_4
                                                            : exmem_q.alu_result;

  assign memwb_d = '{result_src: exmem_q.ctrl.result_src, reg_write: exmem_q.ctrl.reg_write,
                     alu_result: exmem_q.alu_result, rd: exmem_q.rd,
                     pc_plus_4: exmem_q.pc_plus_4};

  stage_reg #(.T(memwb_t)) u_memwb (
    .CLK(CLK), .RST(RST), .stall_i(1'b0), .flush_i(1'b0), .d_i(memwb_d), .q_o(memwb_q)
  );

  //////////////////////////////
  // writeback
  //////////////////////////////
  // load data arrives from memory while the load is in WB
  always_comb begin
    case (memwb_q.result_src)
      RES_MEM: wb_result = dmem_rdata_i;
      RES_PC4: wb_result = memwb_q.pc_plus_4;
      default: wb_result = memwb_q.alu_result;
    endcase
  end

endmodule

// ==== rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and pc width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// word address widths of the two memory ports
`define IMEM_ADDR_W 10
`define DMEM_ADDR_W 10

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSN 32'h0000_0013

`endif

// ==== rv_core_pkg.sv ====
`include "rv_core_config.svh"

package rv_core_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } result_src_e;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // all-zero value is a bubble
  typedef struct packed {
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        branch;
    logic        branch_ne;
    logic        jump;
    logic        alu_b_imm;
    alu_op_e     alu_op;
    result_src_e result_src;
  } ctrl_t;

  typedef struct packed {
    logic [`XLEN-1:0] insn;
    logic [`XLEN-1:0] pc;
  } ifid_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
  } idex_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       pc_plus_4;
  } exmem_t;

  typedef struct packed {
    result_src_e            result_src;
    logic                   reg_write;
    logic [`XLEN-1:0]       alu_result;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       pc_plus_4;
  } memwb_t;

  // data memory request, word addressed
  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [`DMEM_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]        wdata;
  } dmem_req_t;

endpackage

// ==== rv_core_properties.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_props import rv_core_pkg::*; (
  input logic                    CLK,
  input logic                    RST,
  input logic [`IMEM_ADDR_W-1:0] imem_addr_i,
  input dmem_req_t               dmem_i,
  input logic                    stall_i,
  input logic                    redirect_i
);

  // bumped by every failing property, read back by the testbench
  int unsigned assert_fails = 0;

  // the redirecting insn and the flushed bubble behind it never touch memory
  no_access_after_redirect: assert property (@(posedge CLK) disable iff (RST)
    redirect_i |=> !dmem_i.en ##1 !dmem_i.en)
    else begin
      $error("data memory access in the two cycles after a redirect");
      assert_fails++;
    end

  // EX/MEM is cleared by the first reset edge
  no_access_in_reset: assert property (@(posedge CLK) $past(RST) |-> !dmem_i.en)
    else begin
      $error("data memory access while the core is held in reset");
      assert_fails++;
    end

  // a load-use bubble holds the fetch address, unless EX redirects
  fetch_held_on_stall: assert property (@(posedge CLK) disable iff (RST)
    (stall_i && !redirect_i) |=> $stable(imem_addr_i))
    else begin
      $error("fetch address moved during a load-use stall");
      assert_fails++;
    end

endmodule

bind rv_core rv_core_props u_props (
  .CLK(CLK), .RST(RST), .imem_addr_i(imem_addr_o), .dmem_i(dmem_o),
  .stall_i(stall_if_id), .redirect_i(ex_taken)
);

// ==== rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb import rv_core_pkg::*; ();

  localparam int TIMEOUT    = 5000;
  localparam int IMEM_WORDS = 1 << `IMEM_ADDR_W;
  localparam int DMEM_WORDS = 1 << `DMEM_ADDR_W;
  // funct3 per random op, entry 0 in the low bits
  localparam logic [26:0] R_F3 = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [23:0] I_F3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd2, 3'd0};

  logic                    CLK;
  logic                    RST;
  logic [`IMEM_ADDR_W-1:0] imem_addr;
  logic [`XLEN-1:0]        imem_rdata;
  dmem_req_t               dmem_req;
  logic [`XLEN-1:0]        dmem_rdata;
  logic [`XLEN-1:0]        imem [IMEM_WORDS];
  logic [`XLEN-1:0]        dmem [DMEM_WORDS];
  logic [`XLEN-1:0]        prog [$];
  logic [`DMEM_ADDR_W-1:0] exp_addr [$];
  logic [`XLEN-1:0]        exp_data [$];
  logic [31:0]             lcg_state = 32'h5b4a;
  string                   test_name = "";
  int                      seen = 0;
  int                      err_cnt = 0;
  int                      tests_passed = 0;
  int                      tests_failed = 0;

  rv_core DUT (
    .CLK(CLK), .RST(RST), .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
    .dmem_o(dmem_req), .dmem_rdata_i(dmem_rdata)
  );

  always #5 CLK = ~CLK;

  // instruction memory answers in the same cycle
  assign imem_rdata = imem[imem_addr];

  // data memory returns the word one cycle after an enabled request
  always @(posedge CLK) begin
    if (dmem_req.en && dmem_req.we) begin
      dmem[dmem_req.addr] <= dmem_req.wdata;
    end
    dmem_rdata <= dmem_req.en ? dmem[dmem_req.addr] : 'x;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill_word(int a);
    return 32'hc3a5_0000 ^ (a * 32'h0001_0193) ^ (a << 20);
  endfunction

  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  // sw rs2, imm(rs1)
  function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_type(int imm, int rs2, int rs1, bit ne);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 2'b00, ne, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic void emit(logic [31:0] w);
    prog.push_back(w);
  endfunction

  // lui + addi, upper part rounded for the sign of the low 12 bits
  function automatic void load_imm(int rd, logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit({hi[31:12], rd[4:0], OP_LUI});
    emit(i_type(v[11:0], rd, 0, rd, OP_IMM));
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  function automatic logic [31:0] arith_ref(int f3, bit alt, logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    case (f3)
      0: r = alt ? a - b : a + b;
      1: r = a << b[4:0];
      2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4: r = a ^ b;
      5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // runs the loaded program until it jumps to itself, fills the expected store list
  function automatic int iss_run();
    logic [31:0] x [32];
    logic [31:0] mem [DMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    bit          wr;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) mem[i] = fill_word(i);
    exp_addr.delete();
    exp_data.delete();
    pc = `RESET_PC;
    for (int step = 0; step < 4000; step++) begin
      insn    = imem[pc[`IMEM_ADDR_W+1:2]];
      a       = x[insn[19:15]];
      b       = x[insn[24:20]];
      imm     = {{20{insn[31]}}, insn[31:20]};
      next_pc = pc + 4;
      wr      = 1'b1;
      res     = '0;
      case (insn[6:0])
        7'b0110011: res = arith_ref(insn[14:12], insn[30], a, b);
        7'b0010011: res = arith_ref(insn[14:12], insn[30] && insn[14:12] == 3'd5, a, imm);
        7'b0110111: res = {insn[31:12], 12'h000};
        7'b0000011: begin
          ea  = a + imm;
          res = mem[ea[`DMEM_ADDR_W+1:2]];
        end
        7'b0100011: begin
          wr = 1'b0;
          ea = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
          mem[ea[`DMEM_ADDR_W+1:2]] = b;
          exp_addr.push_back(ea[`DMEM_ADDR_W+1:2]);
          exp_data.push_back(b);
        end
        7'b1100011: begin
          wr = 1'b0;
          if ((a == b) != insn[12]) begin
            next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
          end
        end
        7'b1101111: begin
          res     = pc + 4;
          next_pc = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        default: wr = 1'b0;
      endcase
      if (wr && insn[11:7] != 5'd0) x[insn[11:7]] = res;
      if (next_pc == pc) break;
      pc = next_pc;
    end
    return exp_addr.size();
  endfunction

  //////////////////////////////
  // store checker
  //////////////////////////////
  always @(posedge CLK) begin
    if (RST) begin
      seen <= 0;
    end else if (dmem_req.en && dmem_req.we) begin
      assert (seen < exp_addr.size())
        else begin
          $display("%s: unexpected store to word %h after the expected list ended",
                   test_name, dmem_req.addr);
          err_cnt++;
        end
      if (seen < exp_addr.size()) begin
        assert (dmem_req.addr == exp_addr[seen] && dmem_req.wdata == exp_data[seen])
          else begin
            $display("ERR %s: store %0d expected %h @ %h, actual %h @ %h", test_name, seen,
                     exp_data[seen], exp_addr[seen], dmem_req.wdata, dmem_req.addr);
            err_cnt++;
          end
      end
      seen <= seen + 1;
    end
  end

  task automatic hold_reset();
    RST <= 1'b1;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
  endtask

  // reset_at > 0 pulses reset again once that many stores were seen
  task automatic run_test(string name, int reset_at);
    int cycles;
    int errs_before;
    errs_before = err_cnt;
    @(posedge CLK);
    RST <= 1'b1;
    test_name = name;
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = (i < prog.size()) ? prog[i] : `NOP_INSN;
    for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(i);
    void'(iss_run());
    hold_reset();
    cycles = 0;
    while (seen < exp_addr.size() && cycles < TIMEOUT) begin
      @(posedge CLK);
      cycles++;
      if (reset_at > 0 && seen >= reset_at) begin
        reset_at = 0;
        hold_reset();
      end
    end
    if (seen < exp_addr.size()) begin
      $display("%s: timed out with %0d of %0d stores after %0d cycles",
               name, seen, exp_addr.size(), cycles);
      err_cnt++;
    end
    // give stray stores from the shadow of the last jump time to show up
    for (int i = 0; i < 20; i++) @(posedge CLK);
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("[pass] %s, %0d stores", name, exp_addr.size());
    end else begin
      tests_failed++;
      $display("[fail] %s, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // programs
  //////////////////////////////
  task automatic build_random_alu();
    logic [31:0] r;
    logic [11:0] imm12;
    int          op;
    prog.delete();
    for (int i = 1; i < 8; i++) load_imm(i, lcg_next());
    for (int i = 0; i < 40; i++) begin
      r  = lcg_next();
      op = r[31:24] % 17;
      if (op < 9) begin
        emit(r_type((op == 1 || op == 6) ? 32 : 0, 1 + r[7:0] % 7, 1 + r[15:8] % 7,
                    R_F3[op*3 +: 3], 1 + r[23:16] % 7));
      end else begin
        op = op - 9;
        if (op >= 5) imm12 = {(op == 7) ? 7'h20 : 7'h00, r[4:0]};
        else imm12 = r[11:0];
        emit(i_type(imm12, 1 + r[15:8] % 7, I_F3[op*3 +: 3], 1 + r[23:16] % 7, OP_IMM));
      end
    end
    for (int i = 1; i < 8; i++) emit(s_type(32'h100 + 4 * i, i, 0));
    emit(j_type(0, 0));
  endtask

  // instruction k reads the rd of instruction k - d
  task automatic build_dep_chains();
    int rd;
    int rs;
    prog.delete();
    load_imm(5, 32'h1357_9bdf);
    for (int d = 1; d <= 3; d++) begin
      for (int i = 1; i <= 4; i++) load_imm(i, lcg_next());
      for (int k = 0; k < 8; k++) begin
        rd = 1 + k % 4;
        rs = 1 + (k + 4 - d) % 4;
        case (k % 4)
          0: emit(r_type(0, 5, rs, 0, rd));
          1: emit(i_type(12'h7a1, rs, 0, rd, OP_IMM));
          2: emit(r_type(32, rs, 5, 0, rd));
          default: emit(i_type(12'h5c3, rs, 4, rd, OP_IMM));
        endcase
      end
      for (int i = 1; i <= 4; i++) emit(s_type(32'h200 + 16 * d + 4 * i, i, 0));
    end
    emit(j_type(0, 0));
  endtask

  task automatic build_load_use();
    prog.delete();
    load_imm(1, 32'h0bad_f00d);
    load_imm(2, 32'h1234_5678);
    emit(s_type(32'h40, 1, 0));
    emit(i_type(32'h40, 0, 2, 3, OP_LOAD));
    emit(r_type(0, 2, 3, 0, 4));
    emit(s_type(32'h44, 4, 0));
    emit(i_type(32'h40, 0, 2, 5, OP_LOAD));
    emit(r_type(32, 5, 2, 0, 6));
    emit(s_type(32'h48, 6, 0));
    emit(i_type(32'h48, 0, 2, 7, OP_LOAD));
    emit(s_type(32'h4c, 7, 0));
    emit(i_type(32'h1f0, 0, 2, 8, OP_LOAD));
    emit(i_type(1, 8, 0, 8, OP_IMM));
    emit(s_type(32'h50, 8, 0));
    emit(i_type(32'h300, 0, 0, 9, OP_IMM));
    emit(s_type(4, 1, 9));
    emit(i_type(4, 9, 2, 10, OP_LOAD));
    emit(s_type(32'h54, 10, 0));
    emit(j_type(0, 0));
  endtask

  // stores of x9 sit in branch shadows and must never reach memory
  task automatic build_branches();
    prog.delete();
    emit(i_type(5, 0, 0, 1, OP_IMM));
    emit(i_type(5, 0, 0, 2, OP_IMM));
    emit(i_type(7, 0, 0, 3, OP_IMM));
    emit(i_type(32'h5ad, 0, 0, 9, OP_IMM));
    emit(b_type(12, 2, 1, 1'b0));
    emit(i_type(1, 10, 0, 10, OP_IMM));
    emit(s_type(32'h80, 9, 0));
    emit(s_type(32'h84, 1, 0));
    emit(b_type(12, 2, 1, 1'b1));
    emit(s_type(32'h88, 3, 0));
    emit(b_type(12, 3, 1, 1'b1));
    emit(s_type(32'h8c, 9, 0));
    emit(i_type(1, 10, 0, 10, OP_IMM));
    emit(b_type(8, 3, 1, 1'b0));
    emit(s_type(32'h90, 2, 0));
    emit(j_type(12, 11));
    emit(s_type(32'h94, 9, 0));
    emit(i_type(1, 10, 0, 10, OP_IMM));
    emit(s_type(32'h98, 11, 0));
    emit(s_type(32'h9c, 10, 0));
    emit(i_type(3, 0, 0, 6, OP_IMM));
    emit(i_type(-1, 6, 0, 6, OP_IMM));
    emit(s_type(32'ha0, 6, 0));
    emit(b_type(-8, 0, 6, 1'b1));
    emit(j_type(0, 0));
  endtask

  task automatic build_x0_writes();
    prog.delete();
    emit(i_type(77, 0, 0, 1, OP_IMM));
    emit(i_type(123, 0, 0, 0, OP_IMM));
    emit(r_type(0, 1, 1, 0, 0));
    emit(r_type(0, 0, 0, 0, 4));
    emit({20'h12345, 5'd0, OP_LUI});
    emit(s_type(32'hc0, 0, 0));
    emit(s_type(32'hc4, 4, 0));
    emit(i_type(-1, 0, 0, 2, OP_IMM));
    emit(s_type(32'hc8, 2, 0));
    emit(r_type(0, 1, 2, 0, 3));
    emit(s_type(32'hcc, 3, 0));
    emit(s_type(32'hd0, 1, 0));
    emit(j_type(0, 0));
  endtask

  initial begin
    CLK        = 1'b0;
    RST        = 1'b1;
    dmem_rdata = '0;
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = `NOP_INSN;
    build_random_alu();
    run_test("random_alu", 0);
    build_dep_chains();
    run_test("dep_chains", 0);
    build_load_use();
    run_test("load_use", 0);
    build_branches();
    run_test("branches", 0);
    build_x0_writes();
    run_test("x0_and_reset", 2);
    $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_passed, tests_failed, err_cnt, DUT.u_props.assert_fails);
    if (tests_failed == 0 && err_cnt == 0 && DUT.u_props.assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
  parameter type T = logic
) (
  input  logic CLK,
  input  logic RST,
  input  logic stall_i,
  input  logic flush_i,
  input  T     d_i,
  output T     q_o
);

  // a zero payload carries no register write and no memory access
  always_ff @(posedge CLK) begin
    if (RST || flush_i) begin
      q_o <= '0;
    end else if (!stall_i) begin
      q_o <= d_i;
    end
  end

endmodule
